//--- rtl/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

  // One word width serves data, instructions and addresses
  typedef logic [15:0] word_t;

  // Index into the sixteen-entry register file
  typedef logic [3:0] reg_addr_t;

  // Major opcode in instr[15:12]
  typedef enum logic [3:0] {
    op_add  = 4'b0000,
    op_addz = 4'b0001,
    op_sub  = 4'b0010,
    op_and  = 4'b0011,
    op_nor  = 4'b0100,
    op_sll  = 4'b0101,
    op_srl  = 4'b0110,
    op_sra  = 4'b0111,
    op_lw   = 4'b1000,
    op_sw   = 4'b1001,
    op_lhb  = 4'b1010,
    op_llb  = 4'b1011,
    op_b    = 4'b1100,
    op_jal  = 4'b1101,
    op_jr   = 4'b1110,
    op_hlt  = 4'b1111
  } opcode_e;

  // Operation selected inside the ALU
  typedef enum logic [3:0] {
    alu_add = 4'd0,
    alu_sub = 4'd1,
    alu_and = 4'd2,
    alu_nor = 4'd3,
    alu_sll = 4'd4,
    alu_srl = 4'd5,
    alu_sra = 4'd6,
    alu_lhb = 4'd7,
    alu_llb = 4'd8
  } alu_func_e;

  // Branch condition in instr[11:9]
  typedef enum logic [2:0] {
    cond_neq    = 3'b000,
    cond_eq     = 3'b001,
    cond_gt     = 3'b010,
    cond_lt     = 3'b011,
    cond_gte    = 3'b100,
    cond_lte    = 3'b101,
    cond_ovfl   = 3'b110,
    cond_uncond = 3'b111
  } cond_e;

  // JAL return address lands here
  localparam reg_addr_t LINK_REG = 4'd15;

endpackage

`default_nettype wire

//--- rtl/instr_decode.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decode (
  input  cpu_pkg::word_t     instr,
  input  cpu_pkg::word_t     pc,
  input  cpu_pkg::word_t     jr_target,
  input  logic               zr,
  input  logic               ne,
  input  logic               ov,
  output cpu_pkg::reg_addr_t rs_addr,
  output cpu_pkg::reg_addr_t rt_addr,
  output cpu_pkg::reg_addr_t rd_addr,
  output logic               rf_we,
  output cpu_pkg::alu_func_e alu_func,
  output logic [3:0]         shamt,
  output cpu_pkg::word_t     imm,
  output logic               src1_imm,
  output logic               mem_re,
  output logic               mem_we,
  output logic               mem_to_reg,
  output logic               link,
  output logic               upd_zr,
  output logic               upd_nv,
  output cpu_pkg::word_t     next_pc,
  output logic               halt
);

  cpu_pkg::opcode_e opcode;
  cpu_pkg::cond_e   cond;
  cpu_pkg::word_t   pc_inc;
  cpu_pkg::word_t   br_off;
  cpu_pkg::word_t   jal_off;
  logic             taken;
  logic             wr_en;

  assign opcode = cpu_pkg::opcode_e'(instr[15:12]);
  assign cond   = cpu_pkg::cond_e'(instr[11:9]);

  // Sequential address and the two sign-extended jump offsets
  assign pc_inc  = pc + 16'd1;
  assign br_off  = {{7{instr[8]}}, instr[8:0]};
  assign jal_off = {{4{instr[11]}}, instr[11:0]};

  // Shift amount always sits in the low nibble
  assign shamt = instr[3:0];

  // Flag test for conditional branches
  always_comb begin
    case (cond)
      cpu_pkg::cond_neq:  taken = !zr;
      cpu_pkg::cond_eq:   taken = zr;
      cpu_pkg::cond_gt:   taken = !zr && !ne;
      cpu_pkg::cond_lt:   taken = ne;
      cpu_pkg::cond_gte:  taken = !ne;
      cpu_pkg::cond_lte:  taken = ne || zr;
      cpu_pkg::cond_ovfl: taken = ov;
      default:            taken = 1'b1;
    endcase
  end

  always_comb begin
    // R-type field layout by default
    rs_addr    = instr[7:4];
    rt_addr    = instr[3:0];
    rd_addr    = instr[11:8];
    wr_en      = 1'b0;
    alu_func   = cpu_pkg::alu_add;
    imm        = '0;
    src1_imm   = 1'b0;
    mem_re     = 1'b0;
    mem_we     = 1'b0;
    mem_to_reg = 1'b0;
    link       = 1'b0;
    upd_zr     = 1'b0;
    upd_nv     = 1'b0;
    halt       = 1'b0;
    next_pc    = pc_inc;
    case (opcode)
      cpu_pkg::op_add: begin
        wr_en  = 1'b1;
        upd_zr = 1'b1;
        upd_nv = 1'b1;
      end
      cpu_pkg::op_addz: begin
        // Conditional write on the Z flag of an earlier instruction
        wr_en  = zr;
        upd_zr = 1'b1;
        upd_nv = 1'b1;
      end
      cpu_pkg::op_sub: begin
        wr_en    = 1'b1;
        alu_func = cpu_pkg::alu_sub;
        upd_zr   = 1'b1;
        upd_nv   = 1'b1;
      end
      cpu_pkg::op_and: begin
        wr_en    = 1'b1;
        alu_func = cpu_pkg::alu_and;
        upd_zr   = 1'b1;
      end
      cpu_pkg::op_nor: begin
        wr_en    = 1'b1;
        alu_func = cpu_pkg::alu_nor;
        upd_zr   = 1'b1;
      end
      cpu_pkg::op_sll: begin
        wr_en    = 1'b1;
        alu_func = cpu_pkg::alu_sll;
        upd_zr   = 1'b1;
      end
      cpu_pkg::op_srl: begin
        wr_en    = 1'b1;
        alu_func = cpu_pkg::alu_srl;
        upd_zr   = 1'b1;
      end
      cpu_pkg::op_sra: begin
        wr_en    = 1'b1;
        alu_func = cpu_pkg::alu_sra;
        upd_zr   = 1'b1;
      end
      cpu_pkg::op_lw: begin
        // Base register plus 4-bit signed offset
        wr_en      = 1'b1;
        imm        = {{12{instr[3]}}, instr[3:0]};
        src1_imm   = 1'b1;
        mem_re     = 1'b1;
        mem_to_reg = 1'b1;
      end
      cpu_pkg::op_sw: begin
        // Store data comes from rd on the second read port
        rt_addr  = instr[11:8];
        imm      = {{12{instr[3]}}, instr[3:0]};
        src1_imm = 1'b1;
        mem_we   = 1'b1;
      end
      cpu_pkg::op_lhb: begin
        // Old rd value feeds the ALU so the low byte survives
        rs_addr  = instr[11:8];
        wr_en    = 1'b1;
        alu_func = cpu_pkg::alu_lhb;
        imm      = {8'h00, instr[7:0]};
        src1_imm = 1'b1;
      end
      cpu_pkg::op_llb: begin
        wr_en    = 1'b1;
        alu_func = cpu_pkg::alu_llb;
        imm      = {{8{instr[7]}}, instr[7:0]};
        src1_imm = 1'b1;
      end
      cpu_pkg::op_b: begin
        if (taken) begin
          next_pc = pc_inc + br_off;
        end
      end
      cpu_pkg::op_jal: begin
        rd_addr = cpu_pkg::LINK_REG;
        wr_en   = 1'b1;
        link    = 1'b1;
        next_pc = pc_inc + jal_off;
      end
      cpu_pkg::op_jr: begin
        next_pc = jr_target;
      end
      default: begin
        // HLT parks the PC on itself
        halt    = 1'b1;
        next_pc = pc;
      end
    endcase
  end

  // R0 is never a real destination
  assign rf_we = wr_en && (rd_addr != 4'd0);

endmodule

`default_nettype wire

//--- rtl/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  logic               clk,
  input  logic               rst_n,
  input  cpu_pkg::reg_addr_t rs_addr,
  input  cpu_pkg::reg_addr_t rt_addr,
  input  cpu_pkg::reg_addr_t rd_addr,
  input  logic               we,
  input  cpu_pkg::word_t     wdata,
  output cpu_pkg::word_t     rs_data,
  output cpu_pkg::word_t     rt_data
);

  cpu_pkg::word_t regs [16];

  // Write port, R0 stays at zero
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 16; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (rd_addr != 4'd0)) begin
      regs[rd_addr] <= wdata;
    end
  end

  // Combinational reads, same-cycle as decode
  assign rs_data = (rs_addr == 4'd0) ? '0 : regs[rs_addr];
  assign rt_data = (rt_addr == 4'd0) ? '0 : regs[rt_addr];

endmodule

`default_nettype wire

//--- rtl/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  cpu_pkg::word_t     a,
  input  cpu_pkg::word_t     b,
  input  cpu_pkg::alu_func_e func,
  input  logic [3:0]         shamt,
  output cpu_pkg::word_t     result,
  output logic               zr,
  output logic               ne,
  output logic               ov
);

  cpu_pkg::word_t sum;
  cpu_pkg::word_t diff;
  logic           add_ov;
  logic           sub_ov;

  assign sum  = a + b;
  assign diff = a - b;

  // Signed overflow: operand signs vs result sign
  assign add_ov = (a[15] == b[15]) && (sum[15] != a[15]);
  assign sub_ov = (a[15] != b[15]) && (diff[15] != a[15]);

  always_comb begin
    case (func)
      cpu_pkg::alu_add: result = sum;
      cpu_pkg::alu_sub: result = diff;
      cpu_pkg::alu_and: result = a & b;
      cpu_pkg::alu_nor: result = ~(a | b);
      cpu_pkg::alu_sll: result = a << shamt;
      cpu_pkg::alu_srl: result = a >> shamt;
      cpu_pkg::alu_sra: result = $signed(a) >>> shamt;
      // Immediate byte on top, keep the low byte of rd
      cpu_pkg::alu_lhb: result = {b[7:0], a[7:0]};
      // Low byte sign-extended to a full word
      cpu_pkg::alu_llb: result = {{8{b[7]}}, b[7:0]};
      default:          result = sum;
    endcase
  end

  always_comb begin
    case (func)
      cpu_pkg::alu_add: ov = add_ov;
      cpu_pkg::alu_sub: ov = sub_ov;
      default:          ov = 1'b0;
    endcase
  end

  // Z and N come straight off the result
  assign zr = (result == 16'h0000);
  assign ne = result[15];

endmodule

`default_nettype wire

//--- rtl/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top (
  input  logic           clk,
  input  logic           rst_n,
  output cpu_pkg::word_t instr_addr,
  input  cpu_pkg::word_t instr,
  output cpu_pkg::word_t mem_addr,
  output cpu_pkg::word_t mem_wdata,
  output logic           mem_re,
  output logic           mem_we,
  input  cpu_pkg::word_t mem_rdata,
  output logic           halted
);

  cpu_pkg::word_t     pc;
  cpu_pkg::word_t     pc_inc;
  cpu_pkg::word_t     next_pc;
  logic               flag_zr;
  logic               flag_ne;
  logic               flag_ov;
  cpu_pkg::reg_addr_t rs_addr;
  cpu_pkg::reg_addr_t rt_addr;
  cpu_pkg::reg_addr_t rd_addr;
  logic               dec_rf_we;
  cpu_pkg::alu_func_e alu_func;
  logic [3:0]         shamt;
  cpu_pkg::word_t     imm;
  logic               src1_imm;
  logic               dec_mem_re;
  logic               dec_mem_we;
  logic               mem_to_reg;
  logic               link;
  logic               upd_zr;
  logic               upd_nv;
  logic               halt;
  cpu_pkg::word_t     rs_data;
  cpu_pkg::word_t     rt_data;
  cpu_pkg::word_t     alu_b;
  cpu_pkg::word_t     alu_result;
  logic               alu_zr;
  logic               alu_ne;
  logic               alu_ov;
  cpu_pkg::word_t     wb_data;

  assign instr_addr = pc;
  assign pc_inc     = pc + 16'd1;

  instr_decode i_instr_decode (
    .instr      (instr),
    .pc         (pc),
    .jr_target  (rs_data),
    .zr         (flag_zr),
    .ne         (flag_ne),
    .ov         (flag_ov),
    .rs_addr    (rs_addr),
    .rt_addr    (rt_addr),
    .rd_addr    (rd_addr),
    .rf_we      (dec_rf_we),
    .alu_func   (alu_func),
    .shamt      (shamt),
    .imm        (imm),
    .src1_imm   (src1_imm),
    .mem_re     (dec_mem_re),
    .mem_we     (dec_mem_we),
    .mem_to_reg (mem_to_reg),
    .link       (link),
    .upd_zr     (upd_zr),
    .upd_nv     (upd_nv),
    .next_pc    (next_pc),
    .halt       (halt)
  );

  // Write-back: link address, load data or ALU result
  assign wb_data = link ? pc_inc : (mem_to_reg ? mem_rdata : alu_result);

  reg_file i_reg_file (
    .clk     (clk),
    .rst_n   (rst_n),
    .rs_addr (rs_addr),
    .rt_addr (rt_addr),
    .rd_addr (rd_addr),
    .we      (dec_rf_we && !halted),
    .wdata   (wb_data),
    .rs_data (rs_data),
    .rt_data (rt_data)
  );

  // Second operand is register or extended immediate
  assign alu_b = src1_imm ? imm : rt_data;

  alu i_alu (
    .a      (rs_data),
    .b      (alu_b),
    .func   (alu_func),
    .shamt  (shamt),
    .result (alu_result),
    .zr     (alu_zr),
    .ne     (alu_ne),
    .ov     (alu_ov)
  );

  // Data memory port; address is base plus offset from the ALU
  assign mem_addr  = alu_result;
  assign mem_wdata = rt_data;
  assign mem_re    = dec_mem_re && !halted;
  assign mem_we    = dec_mem_we && !halted;

  // PC freezes once halted
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= '0;
    end else if (!halted) begin
      pc <= next_pc;
    end
  end

  // Z loads on its own; N and V load together
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flag_zr <= 1'b0;
      flag_ne <= 1'b0;
      flag_ov <= 1'b0;
    end else if (!halted) begin
      if (upd_zr) begin
        flag_zr <= alu_zr;
      end
      if (upd_nv) begin
        flag_ne <= alu_ne;
        flag_ov <= alu_ov;
      end
    end
  end

  // Sticky until reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      halted <= 1'b0;
    end else if (halt) begin
      halted <= 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- bench/cpu_props.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_props (
  input logic           clk,
  input logic           rst_n,
  input logic           mem_re,
  input logic           mem_we,
  input logic           halted,
  input cpu_pkg::word_t instr_addr
);

  // Read by the testbench top for the final verdict
  int fail_count = 0;

  // A single instruction never both loads and stores
  a_mem_excl: assert property (@(posedge clk) disable iff (!rst_n) !(mem_re && mem_we))
    else begin
      $error("mem_re and mem_we high in the same cycle");
      fail_count++;
    end

  // Halted is sticky until reset
  a_halt_sticky: assert property (@(posedge clk) disable iff (!rst_n) halted |=> halted)
    else begin
      $error("halted fell without reset");
      fail_count++;
    end

  // PC frozen once halted
  a_pc_hold: assert property (@(posedge clk) disable iff (!rst_n)
                              halted |=> $stable(instr_addr))
    else begin
      $error("instr_addr moved while halted");
      fail_count++;
    end

  a_no_store: assert property (@(posedge clk) disable iff (!rst_n) halted |-> !mem_we)
    else begin
      $error("mem_we high while halted");
      fail_count++;
    end

endmodule

bind cpu_top cpu_props i_cpu_props (
  .clk        (clk),
  .rst_n      (rst_n),
  .mem_re     (mem_re),
  .mem_we     (mem_we),
  .halted     (halted),
  .instr_addr (instr_addr)
);

`default_nettype wire

//--- bench/cpu_checker.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_checker (
  input logic           clk,
  input logic           rst_n,
  input cpu_pkg::word_t instr_addr,
  input cpu_pkg::word_t mem_addr,
  input cpu_pkg::word_t mem_wdata,
  input logic           mem_re,
  input logic           mem_we,
  input logic           halted
);

  // Architectural state of the reference model
  cpu_pkg::word_t mdl_pc;
  cpu_pkg::word_t mdl_regs [16];
  cpu_pkg::word_t mdl_mem [256];
  logic           mdl_zr;
  logic           mdl_ne;
  logic           mdl_ov;
  logic           mdl_halted;

  // Memory access that the current instruction should present
  logic           exp_re;
  logic           exp_we;
  cpu_pkg::word_t exp_addr;
  cpu_pkg::word_t exp_wdata;

  int err_count = 0;

  task automatic flag_mismatch(input string what, input cpu_pkg::word_t exp,
                               input cpu_pkg::word_t act);
    $display("CHECK FAILED %s %s: expected %h actual %h", tb_cpu.test_name, what, exp, act);
    err_count++;
  endtask

  // Executes one instruction on the model state, straight from the ISA rules
  function automatic void exec_one(input cpu_pkg::word_t ins);
    logic [3:0]     op;
    logic [3:0]     rd;
    cpu_pkg::word_t a;
    cpu_pkg::word_t b;
    cpu_pkg::word_t r;
    cpu_pkg::word_t addr;
    cpu_pkg::word_t pc1;
    cpu_pkg::word_t nxt;
    logic           v;
    logic           wr;
    logic           set_z;
    logic           set_nv;
    logic           take;
    op     = ins[15:12];
    rd     = ins[11:8];
    a      = mdl_regs[ins[7:4]];
    b      = mdl_regs[ins[3:0]];
    addr   = a + {{12{ins[3]}}, ins[3:0]};
    pc1    = mdl_pc + 16'd1;
    nxt    = pc1;
    r      = '0;
    v      = 1'b0;
    wr     = 1'b0;
    set_z  = 1'b0;
    set_nv = 1'b0;
    take   = 1'b0;
    exp_re = 1'b0;
    exp_we = 1'b0;
    case (op)
      4'h0, 4'h1: begin
        r      = a + b;
        v      = (a[15] == b[15]) && (r[15] != a[15]);
        // ADDZ writes only on a Z left by an earlier instruction
        wr     = (op == 4'h0) ? 1'b1 : mdl_zr;
        set_z  = 1'b1;
        set_nv = 1'b1;
      end
      4'h2: begin
        r      = a - b;
        v      = (a[15] != b[15]) && (r[15] != a[15]);
        wr     = 1'b1;
        set_z  = 1'b1;
        set_nv = 1'b1;
      end
      4'h3, 4'h4, 4'h5, 4'h6, 4'h7: begin
        case (op)
          4'h3:    r = a & b;
          4'h4:    r = ~(a | b);
          4'h5:    r = a << ins[3:0];
          4'h6:    r = a >> ins[3:0];
          default: r = $signed(a) >>> ins[3:0];
        endcase
        wr    = 1'b1;
        set_z = 1'b1;
      end
      4'h8: begin
        exp_re   = 1'b1;
        exp_addr = addr;
        r        = mdl_mem[addr[7:0]];
        wr       = 1'b1;
      end
      4'h9: begin
        exp_we    = 1'b1;
        exp_addr  = addr;
        exp_wdata = mdl_regs[rd];
        mdl_mem[addr[7:0]] = mdl_regs[rd];
      end
      4'hA: begin
        r  = {ins[7:0], mdl_regs[rd][7:0]};
        wr = 1'b1;
      end
      4'hB: begin
        r  = {{8{ins[7]}}, ins[7:0]};
        wr = 1'b1;
      end
      4'hC: begin
        case (ins[11:9])
          3'd0:    take = !mdl_zr;
          3'd1:    take = mdl_zr;
          3'd2:    take = !mdl_zr && !mdl_ne;
          3'd3:    take = mdl_ne;
          3'd4:    take = !mdl_ne;
          3'd5:    take = mdl_ne || mdl_zr;
          3'd6:    take = mdl_ov;
          default: take = 1'b1;
        endcase
        if (take) begin
          nxt = pc1 + {{7{ins[8]}}, ins[8:0]};
        end
      end
      4'hD: begin
        rd  = 4'd15;
        r   = pc1;
        wr  = 1'b1;
        nxt = pc1 + {{4{ins[11]}}, ins[11:0]};
      end
      4'hE: nxt = a;
      default: begin
        mdl_halted = 1'b1;
        nxt        = mdl_pc;
      end
    endcase
    if (set_z) begin
      mdl_zr = (r == 16'h0000);
    end
    if (set_nv) begin
      mdl_ne = r[15];
      mdl_ov = v;
    end
    if (wr && rd != 4'd0) begin
      mdl_regs[rd] = r;
    end
    mdl_pc = nxt;
  endfunction

  // Samples on the rising edge, before the DUT state moves
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mdl_pc     = '0;
      mdl_zr     = 1'b0;
      mdl_ne     = 1'b0;
      mdl_ov     = 1'b0;
      mdl_halted = 1'b0;
      for (int i = 0; i < 16; i++) begin
        mdl_regs[i] = '0;
      end
      // RAM image the bench preloaded for this test
      for (int i = 0; i < 256; i++) begin
        mdl_mem[i] = tb_cpu.ram[i];
      end
    end else if (mdl_halted) begin
      if (!halted) begin
        flag_mismatch("halted", 16'h0001, 16'h0000);
      end
      if (instr_addr != mdl_pc) begin
        flag_mismatch("fetch after halt", mdl_pc, instr_addr);
      end
      if (mem_re) begin
        flag_mismatch("load after halt", 16'h0000, 16'h0001);
      end
      if (mem_we) begin
        flag_mismatch("store after halt", 16'h0000, 16'h0001);
      end
    end else begin
      if (halted) begin
        flag_mismatch("halted", 16'h0000, 16'h0001);
      end
      if (instr_addr != mdl_pc) begin
        flag_mismatch("fetch", mdl_pc, instr_addr);
      end
      exec_one(tb_cpu.rom[mdl_pc[7:0]]);
      if (mem_re != exp_re) begin
        flag_mismatch("load enable", {15'h0, exp_re}, {15'h0, mem_re});
      end else if (exp_re && mem_addr != exp_addr) begin
        flag_mismatch("load address", exp_addr, mem_addr);
      end
      if (mem_we != exp_we) begin
        flag_mismatch("store enable", {15'h0, exp_we}, {15'h0, mem_we});
      end else if (exp_we) begin
        if (mem_addr != exp_addr) begin
          flag_mismatch("store address", exp_addr, mem_addr);
        end
        if (mem_wdata != exp_wdata) begin
          flag_mismatch("store data", exp_wdata, mem_wdata);
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- bench/tb_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu;

  localparam int HALT_TIMEOUT = 500;

  logic           clk;
  logic           rst_n;
  cpu_pkg::word_t instr_addr;
  cpu_pkg::word_t instr;
  cpu_pkg::word_t mem_addr;
  cpu_pkg::word_t mem_wdata;
  cpu_pkg::word_t mem_rdata;
  logic           mem_re;
  logic           mem_we;
  logic           halted;

  // Instruction ROM and data RAM, 256 words each
  cpu_pkg::word_t rom [256];
  cpu_pkg::word_t ram [256];

  string  test_name;
  integer seed;
  int     wr_ptr;
  int     marker;
  int     tests_run;
  int     tests_failed;

  initial begin
    clk = 1'b0;
  end

  always #20 clk = ~clk;

  // Both memories answer in the same cycle
  assign instr     = rom[instr_addr[7:0]];
  assign mem_rdata = ram[mem_addr[7:0]];

  always @(posedge clk) begin
    if (rst_n && mem_we) begin
      ram[mem_addr[7:0]] <= mem_wdata;
    end
  end

  cpu_top i_cpu_top (
    .clk        (clk),
    .rst_n      (rst_n),
    .instr_addr (instr_addr),
    .instr      (instr),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .mem_re     (mem_re),
    .mem_we     (mem_we),
    .mem_rdata  (mem_rdata),
    .halted     (halted)
  );

  cpu_checker i_cpu_checker (
    .clk        (clk),
    .rst_n      (rst_n),
    .instr_addr (instr_addr),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .mem_re     (mem_re),
    .mem_we     (mem_we),
    .halted     (halted)
  );

  // Instruction encoders
  function automatic cpu_pkg::word_t r_op(input cpu_pkg::opcode_e op, input int rd,
                                          input int rs, input int rt);
    return {op, 4'(rd), 4'(rs), 4'(rt)};
  endfunction

  function automatic cpu_pkg::word_t mem_op(input cpu_pkg::opcode_e op, input int rd,
                                            input int base, input int off);
    return {op, 4'(rd), 4'(base), 4'(off)};
  endfunction

  function automatic cpu_pkg::word_t byte_op(input cpu_pkg::opcode_e op, input int rd,
                                             input int value);
    return {op, 4'(rd), 8'(value)};
  endfunction

  function automatic cpu_pkg::word_t br_op(input int cond, input int off);
    return {cpu_pkg::op_b, 3'(cond), 9'(off)};
  endfunction

  function automatic int rand_byte();
    return $random(seed) & 32'hFF;
  endfunction

  // Shift amount in 1..15 so every shift moves bits
  function automatic int rand_shift();
    return (rand_byte() % 15) + 1;
  endfunction

  function automatic int error_total();
    return i_cpu_checker.err_count + i_cpu_top.i_cpu_props.fail_count;
  endfunction

  // Spare code is HLT so a runaway PC stops; data varies with every address bit
  task automatic fill_memories();
    for (int a = 0; a < 256; a++) begin
      rom[a] = {cpu_pkg::op_hlt, 4'h0, 8'(a)};
      ram[a] = (16'(a) * 16'h9E37) ^ 16'h5A5A;
    end
  endtask

  task automatic put(input cpu_pkg::word_t w);
    rom[wr_ptr] = w;
    wr_ptr++;
  endtask

  // Branch by one, over a marker write that shows whether it fell through
  task automatic skip_on(input int cond);
    put(br_op(cond, 1));
    put(byte_op(cpu_pkg::op_llb, 9, marker));
    marker++;
  endtask

  task automatic begin_test(input string name);
    @(negedge clk);
    rst_n     = 1'b0;
    test_name = name;
    wr_ptr    = 0;
    fill_memories();
  endtask

  // Releases reset, waits for halt, then a few idle cycles under the checker
  task automatic run_program();
    int   errs_before;
    int   cycles;
    int   errs;
    logic timed_out;
    errs_before = error_total();
    repeat (4) @(negedge clk);
    rst_n  = 1'b1;
    cycles = 0;
    while (!halted && cycles < HALT_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    timed_out = !halted;
    if (timed_out) begin
      $display("ERROR %s: halted did not rise within %0d cycles", test_name, HALT_TIMEOUT);
    end else begin
      repeat (4) @(negedge clk);
    end
    errs = error_total() - errs_before + int'(timed_out);
    tests_run++;
    if (errs != 0) begin
      tests_failed++;
    end
    $display("test %s done after %0d cycles, %0d errors", test_name, cycles, errs);
  endtask

  initial begin
    rst_n        = 1'b0;
    seed         = 70;
    marker       = 1;
    tests_run    = 0;
    tests_failed = 0;
    test_name    = "init";
    wr_ptr       = 0;
    fill_memories();

    // Random operands through every ALU operation, results stored at 0..6
    // R2 is kept negative so SRA must copy the sign bit
    begin_test("alu");
    put(byte_op(cpu_pkg::op_llb, 1, rand_byte()));
    put(byte_op(cpu_pkg::op_lhb, 1, rand_byte()));
    put(byte_op(cpu_pkg::op_llb, 2, rand_byte()));
    put(byte_op(cpu_pkg::op_lhb, 2, rand_byte() | 8'h80));
    put(r_op(cpu_pkg::op_add, 3, 1, 2));
    put(r_op(cpu_pkg::op_sub, 4, 1, 2));
    put(r_op(cpu_pkg::op_and, 5, 1, 2));
    put(r_op(cpu_pkg::op_nor, 6, 1, 2));
    put(r_op(cpu_pkg::op_sll, 7, 1, rand_shift()));
    put(r_op(cpu_pkg::op_srl, 8, 1, rand_shift()));
    put(r_op(cpu_pkg::op_sra, 9, 2, rand_shift()));
    for (int i = 0; i < 7; i++) begin
      put(mem_op(cpu_pkg::op_sw, 3 + i, 0, i));
    end
    put(cpu_pkg::op_hlt << 12);
    run_program();

    // Eight conditions after overflow, zero, negative and positive flag states
    begin_test("branch");
    put(byte_op(cpu_pkg::op_llb, 1, 8'h7F));
    put(byte_op(cpu_pkg::op_lhb, 1, 8'h7F));
    put(r_op(cpu_pkg::op_add, 2, 1, 1));
    for (int c = 0; c < 8; c++) begin
      skip_on(c);
    end
    put(r_op(cpu_pkg::op_sub, 3, 1, 1));
    for (int c = 0; c < 8; c++) begin
      skip_on(c);
    end
    put(byte_op(cpu_pkg::op_llb, 4, 1));
    put(r_op(cpu_pkg::op_sub, 5, 0, 4));
    for (int c = 0; c < 8; c++) begin
      skip_on(c);
    end
    // One minus zero leaves Z and N both clear
    put(r_op(cpu_pkg::op_sub, 6, 4, 0));
    for (int c = 0; c < 8; c++) begin
      skip_on(c);
    end
    // Forward hop, then a backward branch
    put(br_op(7, 2));
    put(br_op(7, 2));
    put(byte_op(cpu_pkg::op_llb, 9, 8'h55));
    put(br_op(7, -3));
    put(mem_op(cpu_pkg::op_sw, 9, 0, 0));
    put(cpu_pkg::op_hlt << 12);
    run_program();

    // ADDZ once with Z set, once with Z clear
    begin_test("addz");
    put(byte_op(cpu_pkg::op_llb, 1, 5));
    put(byte_op(cpu_pkg::op_llb, 2, 3));
    put(r_op(cpu_pkg::op_sub, 3, 1, 1));
    put(r_op(cpu_pkg::op_addz, 4, 1, 2));
    put(r_op(cpu_pkg::op_addz, 5, 1, 2));
    put(mem_op(cpu_pkg::op_sw, 4, 0, 0));
    put(mem_op(cpu_pkg::op_sw, 5, 0, 1));
    put(cpu_pkg::op_hlt << 12);
    run_program();

    // Loads around base 20, each copied back to 1..4
    begin_test("load");
    ram[12] = 16'h8000;
    put(byte_op(cpu_pkg::op_llb, 1, 20));
    put(mem_op(cpu_pkg::op_lw, 2, 1, 7));
    put(mem_op(cpu_pkg::op_lw, 3, 1, -8));
    put(mem_op(cpu_pkg::op_lw, 4, 1, -1));
    put(mem_op(cpu_pkg::op_lw, 5, 1, 0));
    for (int i = 0; i < 4; i++) begin
      put(mem_op(cpu_pkg::op_sw, 2 + i, 0, 1 + i));
    end
    put(cpu_pkg::op_hlt << 12);
    run_program();

    // JAL to 5, JR back through R15 to 2
    begin_test("jal_jr");
    put(byte_op(cpu_pkg::op_llb, 1, 8'h21));
    put({cpu_pkg::op_jal, 12'd3});
    put(mem_op(cpu_pkg::op_sw, 15, 0, 0));
    put(mem_op(cpu_pkg::op_sw, 1, 0, 1));
    put(cpu_pkg::op_hlt << 12);
    put(byte_op(cpu_pkg::op_llb, 1, 8'h42));
    put({cpu_pkg::op_jr, 4'h0, 4'd15, 4'h0});
    run_program();

    // Store right after HLT must never issue
    begin_test("halt");
    put(byte_op(cpu_pkg::op_llb, 1, 7));
    put(mem_op(cpu_pkg::op_sw, 1, 0, 0));
    put(cpu_pkg::op_hlt << 12);
    put(mem_op(cpu_pkg::op_sw, 1, 0, 1));
    run_program();

    $display("summary: %0d tests, %0d passed, %0d failed, %0d errors",
             tests_run, tests_run - tests_failed, tests_failed, error_total());
    if (tests_failed == 0 && error_total() == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- cpu_top.f
rtl/cpu_pkg.sv
rtl/instr_decode.sv
rtl/reg_file.sv
rtl/alu.sv
rtl/cpu_top.sv
bench/cpu_props.sv
bench/cpu_checker.sv
bench/tb_cpu.sv

//--- Bender.yml
package:
  name: cpu_top

sources:
  - rtl/cpu_pkg.sv
  - rtl/instr_decode.sv
  - rtl/reg_file.sv
  - rtl/alu.sv
  - rtl/cpu_top.sv
  - target: test
    files:
      - bench/cpu_props.sv
      - bench/cpu_checker.sv
      - bench/tb_cpu.sv
